//--- cache_pkg.sv
package cache_pkg;

  // address and data widths of the hart and memory ports
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned WORD_W = 32;

  // one mask bit per byte of a word
  localparam int unsigned MASK_W = WORD_W / 8;

  // a 16 byte line is indexed by the low four address bits
  localparam int unsigned OFFSET_W = 4;

  // 32 sets need five index bits taken just above the line offset
  localparam int unsigned INDEX_W = 5;
  localparam int unsigned SETS = 1 << INDEX_W;

  // two ways per set give a way number of a single bit
  localparam int unsigned WAYS = 2;

  // a line holds four words picked by address bits [3:2]
  localparam int unsigned WORDS_PER_LINE = 4;
  localparam int unsigned WORD_SEL_W = 2;

  // everything above the index is tag
  localparam int unsigned TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  // request and memory address
  typedef logic [ADDR_W-1:0] addr_t;

  // one data word
  typedef logic [WORD_W-1:0] word_t;

  // byte enables of a word
  typedef logic [MASK_W-1:0] mask_t;

  // stored tag of a line
  typedef logic [TAG_W-1:0] tag_t;

  // set number
  typedef logic [INDEX_W-1:0] index_t;

  // word position inside a line
  typedef logic [WORD_SEL_W-1:0] word_sel_t;

  // way number inside a set
  typedef logic [$clog2(WAYS)-1:0] way_t;

endpackage

//--- cache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store (
  input  logic              i_clk,
  input  logic              i_rst,
  input  cache_pkg::addr_t  i_req_addr,
  input  logic              i_fill_done,
  input  cache_pkg::way_t   i_fill_way,
  input  logic              i_touch,
  output logic              o_hit,
  output cache_pkg::way_t   o_hit_way,
  output cache_pkg::way_t   o_victim_way
);

  // tags of both ways, one entry per set
  cache_pkg::tag_t tag_q [cache_pkg::WAYS][cache_pkg::SETS];

  // valid bit of each way, cleared by reset
  logic [cache_pkg::WAYS-1:0] valid_q [cache_pkg::SETS];

  // lru_q holds the way that was used least recently in each set
  cache_pkg::way_t lru_q [cache_pkg::SETS];

  cache_pkg::tag_t   req_tag;
  cache_pkg::index_t req_index;
  logic [cache_pkg::WAYS-1:0] way_hit;

  // split the request address into tag and set index
  assign req_tag   = i_req_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign req_index = i_req_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];

  // a way hits when it is valid and its tag matches
  always_comb begin
    for (int w = 0; w < cache_pkg::WAYS; w++) begin
      way_hit[w] = valid_q[req_index][w] && (tag_q[w][req_index] == req_tag);
    end
  end

  assign o_hit     = |way_hit;
  // the hit way is way 1 whenever way 1 hits and way 0 otherwise
  assign o_hit_way = cache_pkg::way_t'(way_hit[1]);

  // empty ways fill first with the lowest way before the other
  always_comb begin
    if (!valid_q[req_index][0]) begin
      o_victim_way = cache_pkg::way_t'(0);
    end else if (!valid_q[req_index][1]) begin
      o_victim_way = cache_pkg::way_t'(1);
    end else begin
      o_victim_way = lru_q[req_index];
    end
  end

  // the new tag goes in when the last word of the fill arrives
  always_ff @(posedge i_clk) begin
    if (i_fill_done) begin
      tag_q[i_fill_way][req_index] <= req_tag;
    end
  end

  // reset invalidates every line and points lru at way 0
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int s = 0; s < cache_pkg::SETS; s++) begin
        valid_q[s] <= '0;
        lru_q[s]   <= '0;
      end
    end else if (i_fill_done) begin
      valid_q[req_index][i_fill_way] <= 1'b1;
      // the freshly filled way becomes most recently used
      lru_q[req_index] <= ~i_fill_way;
    end else if (i_touch) begin
      // a served hit points lru at the other way
      lru_q[req_index] <= ~o_hit_way;
    end
  end

endmodule

`default_nettype wire

//--- cache_line_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_line_store (
  input  logic                  i_clk,
  input  cache_pkg::addr_t      i_req_addr,
  input  cache_pkg::mask_t      i_req_mask,
  input  cache_pkg::word_t      i_req_wdata,
  input  cache_pkg::way_t       i_hit_way,
  input  logic                  i_fill_we,
  input  cache_pkg::way_t       i_fill_way,
  input  cache_pkg::word_sel_t  i_fill_sel,
  input  cache_pkg::word_t      i_fill_data,
  input  logic                  i_write_we,
  output cache_pkg::word_t      o_rdata_masked,
  output cache_pkg::word_t      o_merged_word
);

  // data words of every line
  cache_pkg::word_t data_q [cache_pkg::SETS][cache_pkg::WAYS][cache_pkg::WORDS_PER_LINE];

  cache_pkg::index_t    req_index;
  cache_pkg::word_sel_t req_sel;
  cache_pkg::word_t     stored_word;
  cache_pkg::word_t     byte_mask;

  // set index and word position both come from the held request address
  assign req_index = i_req_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign req_sel   = i_req_addr[cache_pkg::OFFSET_W-cache_pkg::WORD_SEL_W +:
                                cache_pkg::WORD_SEL_W];

  // word of the hit way at the requested position
  assign stored_word = data_q[req_index][i_hit_way][req_sel];

  // widen each mask bit to cover its whole byte
  always_comb begin
    for (int b = 0; b < cache_pkg::MASK_W; b++) begin
      byte_mask[8*b +: 8] = {8{i_req_mask[b]}};
    end
  end

  // read data keeps its lane and bytes outside the mask read as zero
  assign o_rdata_masked = stored_word & byte_mask;

  // selected bytes come from the hart and all others from the cached word
  assign o_merged_word = (i_req_wdata & byte_mask) | (stored_word & ~byte_mask);

  // fill words land in the victim way at the returned position
  // and a committed write stores the merged word in the hit way
  always_ff @(posedge i_clk) begin
    if (i_fill_we) begin
      data_q[req_index][i_fill_way][i_fill_sel] <= i_fill_data;
    end
    if (i_write_we) begin
      data_q[req_index][i_hit_way][req_sel] <= o_merged_word;
    end
  end

endmodule

`default_nettype wire

//--- cache_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_miss_ctrl (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  cache_pkg::addr_t      i_req_addr,
  input  logic                  i_req_ren,
  input  logic                  i_req_wen,
  input  logic                  i_hit,
  input  cache_pkg::way_t       i_victim_way,
  input  cache_pkg::word_t      i_merged_word,
  input  logic                  i_mem_ready,
  input  cache_pkg::word_t      i_mem_rdata,
  input  logic                  i_mem_valid,
  output logic                  o_busy,
  output cache_pkg::addr_t      o_mem_addr,
  output logic                  o_mem_ren,
  output logic                  o_mem_wen,
  output cache_pkg::word_t      o_mem_wdata,
  output cache_pkg::way_t       o_fill_way,
  output logic                  o_fill_we,
  output cache_pkg::word_sel_t  o_fill_sel,
  output cache_pkg::word_t      o_fill_data,
  output logic                  o_fill_done,
  output logic                  o_write_we,
  output logic                  o_touch
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_WRITE
  } state_t;

  state_t state_q;
  state_t state_d;

  // remembers whether the miss came from a write
  logic is_write_q;

  // extra top bit flags that all four reads went out
  logic [cache_pkg::WORD_SEL_W:0] issue_cnt_q;

  // position of the next word that memory returns
  cache_pkg::word_sel_t ret_cnt_q;

  cache_pkg::way_t fill_way_q;

  logic             miss_start;
  logic             issue_go;
  logic             write_go;
  cache_pkg::addr_t fill_addr;

  // a request that misses starts a line fill
  assign miss_start = (state_q == ST_IDLE) && (i_req_ren || i_req_wen) && !i_hit;

  // one read per cycle while ready was seen high and reads remain
  assign issue_go = (state_q == ST_FILL) && !issue_cnt_q[cache_pkg::WORD_SEL_W] &&
                    i_mem_ready;

  // fill reads walk the line from its base address upward
  assign fill_addr = {i_req_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W],
                      issue_cnt_q[cache_pkg::WORD_SEL_W-1:0],
                      {(cache_pkg::OFFSET_W-cache_pkg::WORD_SEL_W){1'b0}}};

  // returned words go straight into the victim way
  assign o_fill_we   = (state_q == ST_FILL) && i_mem_valid;
  assign o_fill_sel  = ret_cnt_q;
  assign o_fill_data = i_mem_rdata;
  assign o_fill_way  = fill_way_q;
  assign o_fill_done = o_fill_we && (ret_cnt_q == cache_pkg::word_sel_t'('1));

  always_comb begin
    state_d  = state_q;
    o_busy   = 1'b0;
    write_go = 1'b0;
    o_touch  = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (miss_start) begin
          // stall the hart in the very cycle of the miss
          o_busy  = 1'b1;
          state_d = ST_FILL;
        end else if (i_req_ren) begin
          o_touch = 1'b1;
        end else if (i_req_wen) begin
          if (i_mem_ready) begin
            write_go = 1'b1;
            o_touch  = 1'b1;
          end else begin
            // hold the hart until memory is ready
            o_busy  = 1'b1;
            state_d = ST_WRITE;
          end
        end
      end
      ST_FILL: begin
        o_busy = 1'b1;
        if (o_fill_done) begin
          // a write miss finishes as a write hit on the new line
          state_d = is_write_q ? ST_WRITE : ST_IDLE;
        end
      end
      ST_WRITE: begin
        // the commit cycle itself is no longer busy
        o_busy = !i_mem_ready;
        if (i_mem_ready) begin
          write_go = 1'b1;
          o_touch  = 1'b1;
          state_d  = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // the line and the memory request update on the same edge
  assign o_write_we = write_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q     <= ST_IDLE;
      is_write_q  <= 1'b0;
      issue_cnt_q <= '0;
      ret_cnt_q   <= '0;
      fill_way_q  <= '0;
      o_mem_ren   <= 1'b0;
      o_mem_wen   <= 1'b0;
    end else begin
      state_q   <= state_d;
      o_mem_ren <= issue_go;
      o_mem_wen <= write_go;
      if (miss_start) begin
        // latch the kind of request and where the line will go
        is_write_q  <= i_req_wen;
        fill_way_q  <= i_victim_way;
        issue_cnt_q <= '0;
        ret_cnt_q   <= '0;
      end else begin
        if (issue_go) begin
          issue_cnt_q <= issue_cnt_q + 1'b1;
        end
        if (o_fill_we) begin
          ret_cnt_q <= ret_cnt_q + 1'b1;
        end
      end
    end
  end

  // the request address and write data load together with their strobes
  always_ff @(posedge i_clk) begin
    if (issue_go) begin
      o_mem_addr <= fill_addr;
    end else if (write_go) begin
      o_mem_addr  <= i_req_addr;
      o_mem_wdata <= i_merged_word;
    end
  end

endmodule

`default_nettype wire

//--- cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  logic              i_clk,
  input  logic              i_rst,
  // hart side
  input  cache_pkg::addr_t  i_req_addr,
  input  logic              i_req_ren,
  input  logic              i_req_wen,
  input  cache_pkg::mask_t  i_req_mask,
  input  cache_pkg::word_t  i_req_wdata,
  output logic              o_busy,
  output cache_pkg::word_t  o_res_rdata,
  // memory side is word wide without byte enables
  output cache_pkg::addr_t  o_mem_addr,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output cache_pkg::word_t  o_mem_wdata,
  input  logic              i_mem_ready,
  input  cache_pkg::word_t  i_mem_rdata,
  input  logic              i_mem_valid
);

  // lookup results from the tag store
  logic                 hit;
  cache_pkg::way_t      hit_way;
  cache_pkg::way_t      victim_way;

  // fill and commit controls from the state machine
  cache_pkg::way_t      fill_way;
  logic                 fill_we;
  cache_pkg::word_sel_t fill_sel;
  cache_pkg::word_t     fill_data;
  logic                 fill_done;
  logic                 write_we;
  logic                 touch;

  // merged store data from the line store
  cache_pkg::word_t     merged_word;

  cache_tag_store u_tag_store (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_req_addr   (i_req_addr),
    .i_fill_done  (fill_done),
    .i_fill_way   (fill_way),
    .i_touch      (touch),
    .o_hit        (hit),
    .o_hit_way    (hit_way),
    .o_victim_way (victim_way)
  );

  cache_line_store u_line_store (
    .i_clk          (i_clk),
    .i_req_addr     (i_req_addr),
    .i_req_mask     (i_req_mask),
    .i_req_wdata    (i_req_wdata),
    .i_hit_way      (hit_way),
    .i_fill_we      (fill_we),
    .i_fill_way     (fill_way),
    .i_fill_sel     (fill_sel),
    .i_fill_data    (fill_data),
    .i_write_we     (write_we),
    .o_rdata_masked (o_res_rdata),
    .o_merged_word  (merged_word)
  );

  cache_miss_ctrl u_miss_ctrl (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_req_addr    (i_req_addr),
    .i_req_ren     (i_req_ren),
    .i_req_wen     (i_req_wen),
    .i_hit         (hit),
    .i_victim_way  (victim_way),
    .i_merged_word (merged_word),
    .i_mem_ready   (i_mem_ready),
    .i_mem_rdata   (i_mem_rdata),
    .i_mem_valid   (i_mem_valid),
    .o_busy        (o_busy),
    .o_mem_addr    (o_mem_addr),
    .o_mem_ren     (o_mem_ren),
    .o_mem_wen     (o_mem_wen),
    .o_mem_wdata   (o_mem_wdata),
    .o_fill_way    (fill_way),
    .o_fill_we     (fill_we),
    .o_fill_sel    (fill_sel),
    .o_fill_data   (fill_data),
    .o_fill_done   (fill_done),
    .o_write_we    (write_we),
    .o_touch       (touch)
  );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
  input  logic              i_clk,
  input  logic              i_rst,
  input  cache_pkg::addr_t  i_addr,
  input  logic              i_ren,
  input  logic              i_wen,
  input  cache_pkg::word_t  i_wdata,
  output logic              o_ready,
  output cache_pkg::word_t  o_rdata,
  output logic              o_valid
);

  // 4 KB of word storage where higher addresses alias
  localparam int unsigned MEM_WORDS = 1024;

  cache_pkg::word_t mem [MEM_WORDS];

  logic [31:0]      rng;
  int unsigned      cycle;
  int unsigned      due;
  int unsigned      last_due;
  cache_pkg::word_t rd_data_q [$];
  int unsigned      rd_due_q [$];

  logic             ready_q = 1'b0;
  logic             valid_q = 1'b0;
  cache_pkg::word_t rdata_q = '0;

  assign o_ready = ready_q;
  assign o_valid = valid_q;
  assign o_rdata = rdata_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // every word mixes the random stream with its own address
  initial begin
    rng = 32'h53c4;
    for (int i = 0; i < MEM_WORDS; i++) begin
      rng = xorshift32(rng);
      mem[i] = rng ^ (32'(i) * 32'h9e37_79b9);
    end
  end

  always @(posedge i_clk) begin
    if (i_rst) begin
      ready_q  <= 1'b0;
      valid_q  <= 1'b0;
      cycle    = 0;
      last_due = 0;
      rd_data_q.delete();
      rd_due_q.delete();
    end else begin
      rng   = xorshift32(rng);
      cycle = cycle + 1;
      // ready is high about three cycles out of four
      ready_q <= (rng[1:0] != 2'b00);
      if (i_wen) begin
        mem[i_addr[11:2]] <= i_wdata;
      end
      if (i_ren) begin
        // latency of 1 to 4 cycles that never overtakes an older read
        due = cycle + 32'(rng[3:2]) + 1;
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rd_data_q.push_back(mem[i_addr[11:2]]);
        rd_due_q.push_back(due);
      end
      valid_q <= 1'b0;
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
        valid_q <= 1'b1;
        rdata_q <= rd_data_q.pop_front();
        void'(rd_due_q.pop_front());
      end
    end
  end

endmodule

//--- tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

  // about four times the cycles of the longest test
  localparam int MAX_CYCLES = 20000;
  localparam int MEM_WORDS = 1024;

  logic             clk = 1'b0;
  logic             rst;
  cache_pkg::addr_t req_addr;
  logic             req_ren;
  logic             req_wen;
  cache_pkg::mask_t req_mask;
  cache_pkg::word_t req_wdata;
  logic             busy;
  cache_pkg::word_t res_rdata;
  cache_pkg::addr_t mem_addr;
  logic             mem_ren;
  logic             mem_wen;
  cache_pkg::word_t mem_wdata;
  logic             mem_ready;
  cache_pkg::word_t mem_rdata;
  logic             mem_valid;

  // expected memory contents that every hart write updates
  cache_pkg::word_t shadow [MEM_WORDS];
  logic [31:0]      rand_state = 32'h53c4;

  string            cur_test;
  int               test_count = 0;
  int               check_count = 0;
  int               error_count = 0;
  int               errors_at_start = 0;
  int               cycles = 0;
  int               rd_count = 0;
  int               rd_at_wr = 0;
  int               wr_count = 0;
  int               wr_expected = 0;
  cache_pkg::addr_t last_wr_addr;
  cache_pkg::word_t last_wr_data;
  cache_pkg::addr_t rd_addrs [$];

  cache_top u_cache_top (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_req_addr  (req_addr),
    .i_req_ren   (req_ren),
    .i_req_wen   (req_wen),
    .i_req_mask  (req_mask),
    .i_req_wdata (req_wdata),
    .o_busy      (busy),
    .o_res_rdata (res_rdata),
    .o_mem_addr  (mem_addr),
    .o_mem_ren   (mem_ren),
    .o_mem_wen   (mem_wen),
    .o_mem_wdata (mem_wdata),
    .i_mem_ready (mem_ready),
    .i_mem_rdata (mem_rdata),
    .i_mem_valid (mem_valid)
  );

  tb_mem_model u_mem (
    .i_clk   (clk),
    .i_rst   (rst),
    .i_addr  (mem_addr),
    .i_ren   (mem_ren),
    .i_wen   (mem_wen),
    .i_wdata (mem_wdata),
    .o_ready (mem_ready),
    .o_rdata (mem_rdata),
    .o_valid (mem_valid)
  );

  always #5 clk = ~clk;

  // registered memory strobes count with the value they held just before the edge
  always @(posedge clk) begin
    if (!rst) begin
      if (mem_ren) begin
        rd_count = rd_count + 1;
        rd_addrs.push_back(mem_addr);
      end
      if (mem_wen) begin
        wr_count     = wr_count + 1;
        rd_at_wr     = rd_count;
        last_wr_addr = mem_addr;
        last_wr_data = mem_wdata;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout in %s, the run passed %0d cycles", cur_test, cycles);
      $display("Errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // each mask bit stands for one whole byte lane
  function automatic cache_pkg::word_t lane_mask(input cache_pkg::mask_t m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  task automatic check_word(input string what, input cache_pkg::word_t exp,
                            input cache_pkg::word_t act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("ERR %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input cache_pkg::addr_t exp,
                            input cache_pkg::addr_t act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("ERR %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_busy(input string what, input logic exp, input logic act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = error_count;
    test_count++;
  endtask

  task automatic finish_test();
    $display("%s finished with %0d errors", cur_test, error_count - errors_at_start);
  endtask

  // one hart request held until busy drops with ren and wen high in its first cycle
  task automatic hart_access(input cache_pkg::addr_t addr, input logic wr,
                             input cache_pkg::mask_t mask, input cache_pkg::word_t wdata,
                             output logic stalled, output cache_pkg::word_t rdata);
    @(posedge clk);
    req_addr  <= addr;
    req_mask  <= mask;
    req_wdata <= wdata;
    req_ren   <= !wr;
    req_wen   <= wr;
    @(negedge clk);
    stalled = busy;
    while (busy) begin
      @(posedge clk);
      req_ren <= 1'b0;
      req_wen <= 1'b0;
      @(negedge clk);
    end
    rdata = res_rdata;
    @(posedge clk);
    req_ren <= 1'b0;
    req_wen <= 1'b0;
  endtask

  task automatic read_and_compare(input cache_pkg::addr_t addr, input cache_pkg::mask_t mask,
                                  input logic busy_known, input logic busy_exp);
    logic             stalled;
    cache_pkg::word_t got;
    hart_access(addr, 1'b0, mask, '0, stalled, got);
    if (busy_known) begin
      check_busy("busy", busy_exp, stalled);
    end
    check_word("read data", shadow[addr[11:2]] & lane_mask(mask), got);
  endtask

  task automatic wait_for_writes();
    while (wr_count < wr_expected) begin
      @(negedge clk);
    end
  endtask

  task automatic write_and_compare(input cache_pkg::addr_t addr, input cache_pkg::mask_t mask,
                                   input cache_pkg::word_t wdata, output logic stalled);
    cache_pkg::word_t expected;
    cache_pkg::word_t unused;
    // masked bytes come from the hart and the others keep their old value
    expected = (wdata & lane_mask(mask)) | (shadow[addr[11:2]] & ~lane_mask(mask));
    shadow[addr[11:2]] = expected;
    wr_expected++;
    hart_access(addr, 1'b1, mask, wdata, stalled, unused);
    wait_for_writes();
    check_addr("write address", addr, last_wr_addr);
    check_word("write data", expected, last_wr_data);
  endtask

  task automatic read_miss_then_hit();
    begin_test("read_miss_then_hit");
    read_and_compare(32'h0000_0038, 4'hf, 1'b1, 1'b1);
    for (int w = 0; w < 4; w++) begin
      read_and_compare(32'h0000_0030 + 32'(4 * w), 4'hf, 1'b1, 1'b0);
    end
    finish_test();
  endtask

  task automatic masked_reads();
    cache_pkg::mask_t masks [6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
    begin_test("masked_reads");
    for (int i = 0; i < 6; i++) begin
      read_and_compare(32'h0000_0030 + 32'(4 * (i % 4)), masks[i], 1'b1, 1'b0);
    end
    finish_test();
  endtask

  task automatic write_through_merge();
    logic stalled;
    begin_test("write_through_merge");
    // all four writes hit the line that the first test brought in
    write_and_compare(32'h0000_0034, 4'b0100, 32'hdead_beef, stalled);
    write_and_compare(32'h0000_0038, 4'b1100, 32'h1234_5678, stalled);
    write_and_compare(32'h0000_0038, 4'b0011, 32'hcafe_f00d, stalled);
    write_and_compare(32'h0000_003c, 4'b0001, 32'h0000_00a5, stalled);
    read_and_compare(32'h0000_0034, 4'hf, 1'b1, 1'b0);
    read_and_compare(32'h0000_0038, 4'hf, 1'b1, 1'b0);
    read_and_compare(32'h0000_003c, 4'hf, 1'b1, 1'b0);
    finish_test();
  endtask

  task automatic write_allocate();
    logic stalled;
    int   rd_before;
    begin_test("write_allocate");
    rd_before = rd_count;
    rd_addrs.delete();
    write_and_compare(32'h0000_0268, 4'b0110, 32'h5a5a_a5a5, stalled);
    check_busy("busy", 1'b1, stalled);
    // all four fill reads go out before the write strobe
    check_count++;
    if (rd_at_wr - rd_before != 4) begin
      error_count++;
      $display("ERR %s fill reads before the write: expected 4, actual %0d",
               cur_test, rd_at_wr - rd_before);
    end else begin
      // the line fills from its base address upward
      for (int k = 0; k < 4; k++) begin
        check_addr("fill address", 32'h0000_0260 + 32'(4 * k), rd_addrs[k]);
      end
    end
    read_and_compare(32'h0000_0260, 4'hf, 1'b1, 1'b0);
    read_and_compare(32'h0000_0264, 4'hf, 1'b1, 1'b0);
    read_and_compare(32'h0000_026c, 4'hf, 1'b1, 1'b0);
    finish_test();
  endtask

  task automatic lru_replacement();
    begin_test("lru_replacement");
    // tags 1, 2 and 3 all map to set 20
    read_and_compare(32'h0000_0340, 4'hf, 1'b1, 1'b1);
    read_and_compare(32'h0000_0540, 4'hf, 1'b1, 1'b1);
    read_and_compare(32'h0000_0340, 4'hf, 1'b1, 1'b0);
    read_and_compare(32'h0000_0740, 4'hf, 1'b1, 1'b1);
    read_and_compare(32'h0000_0340, 4'hf, 1'b1, 1'b0);
    read_and_compare(32'h0000_0540, 4'hf, 1'b1, 1'b1);
    read_and_compare(32'h0000_0340, 4'hf, 1'b1, 1'b0);
    finish_test();
  endtask

  task automatic random_mix();
    logic             stalled;
    logic [31:0]      r;
    cache_pkg::addr_t addr;
    begin_test("random_mix");
    for (int n = 0; n < 300; n++) begin
      rand_state = xorshift32(rand_state);
      r = rand_state;
      // four tags over sets 8 to 11 keep replacement busy
      addr = {21'd0, r[1:0], 3'b010, r[3:2], r[5:4], 2'b00};
      if (r[12]) begin
        rand_state = xorshift32(rand_state);
        write_and_compare(addr, r[11:8], rand_state, stalled);
      end else begin
        read_and_compare(addr, r[11:8], 1'b0, 1'b0);
      end
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_word("memory word", shadow[i], u_mem.mem[i]);
    end
    finish_test();
  endtask

  initial begin
    rst       = 1'b1;
    req_addr  = '0;
    req_ren   = 1'b0;
    req_wen   = 1'b0;
    req_mask  = '0;
    req_wdata = '0;
    cur_test  = "reset";
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    // memory still holds its start contents here
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = u_mem.mem[i];
    end
    read_miss_then_hit();
    masked_reads();
    write_through_merge();
    write_allocate();
    lru_replacement();
    random_mix();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- project.f
cache_pkg.sv
cache_tag_store.sv
cache_line_store.sv
cache_miss_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv

//--- Makefile
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the log holds the pass line
run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
